/* logic/bfPkg.sv */
`default_nettype none

package bfPkg;

    // Decade counter geometry
    localparam int DigitWidth = 4;   // One BCD digit per tube stage
    localparam int IpDigits = 3;
    localparam int LoopDigits = 2;

    localparam int IpWidth = IpDigits * DigitWidth;
    localparam int LoopWidth = LoopDigits * DigitWidth;

    // Program store
    localparam int InsnWidth = 3;
    localparam int RomDepth = 256;
    localparam int RomAddrWidth = $clog2(RomDepth);

    // Instruction set of the bracket-loop language
    typedef enum logic [InsnWidth-1:0] {
        Inc,
        Dec,
        Left,
        Right,
        Out,
        In,
        LoopOpen,   // Skip forward past matching close when cell is zero
        LoopClose   // Jump back to matching open when cell is nonzero
    } opcodeT;

endpackage

`default_nettype wire

/* logic/fetchIfs.sv */
`timescale 1ns/1ps
`default_nettype none

// Step request toward one decade counter
interface counterIf #(
    parameter int DigitNum = 1,
    parameter int Width = DigitNum * bfPkg::DigitWidth
);
    logic Request;   // Single-cycle strobe
    logic Dec;
    logic Ready;
    logic [Width-1:0] Value;
    logic Zero;

    modport master (output Request, output Dec, input Ready, input Value, input Zero);
    modport counter (input Request, input Dec, output Ready, output Value, output Zero);
endinterface

// Read port of the program store
interface romIf;
    import bfPkg::*;

    logic Request;
    logic [IpWidth-1:0] Address;   // BCD pointer value
    logic Ready;
    opcodeT Data;

    modport master (output Request, output Address, input Ready, input Data);
    modport store (input Request, input Address, output Ready, output Data);
endinterface

`default_nettype wire

/* logic/dekatronCounter.sv */
`timescale 1ns/1ps
`default_nettype none

module dekatronCounter #(
    parameter int DigitNum = 1
) (
    input wire logic Clk,
    input wire logic Rst_n,
    counterIf.counter cnt
);
    import bfPkg::*;

    logic [DigitNum*DigitWidth-1:0] value;
    logic [DigitNum*DigitWidth-1:0] valueNext;
    logic [DigitNum-1:0] pending;       // Stage waiting to take one step
    logic [DigitNum-1:0] pendingNext;
    logic down;                         // Direction latched with the request

    // One decimal step of a single tube
    function automatic logic [DigitWidth-1:0] stepDigit(
        input logic [DigitWidth-1:0] digit,
        input logic dn
    );
        if (dn) begin
            return (digit == '0) ? DigitWidth'(9) : digit - 1'b1;
        end else begin
            return (digit == DigitWidth'(9)) ? '0 : digit + 1'b1;
        end
    endfunction

    // Stage passes a carry or borrow to the next one
    function automatic logic wrapsAround(
        input logic [DigitWidth-1:0] digit,
        input logic dn
    );
        return dn ? (digit == '0) : (digit == DigitWidth'(9));
    endfunction

    always_comb begin
        valueNext = value;
        pendingNext = '0;
        pendingNext[0] = cnt.Request;
        for (int i = 0; i < DigitNum; i++) begin
            if (pending[i]) begin
                valueNext[i*DigitWidth +: DigitWidth] =
                    stepDigit(value[i*DigitWidth +: DigitWidth], down);
            end
        end
        // Carry moves up one stage per cycle, top stage overflow is lost
        for (int i = 1; i < DigitNum; i++) begin
            pendingNext[i] = pending[i-1] &
                wrapsAround(value[(i-1)*DigitWidth +: DigitWidth], down);
        end
    end

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            value <= '0;
            pending <= '0;
            down <= 1'b0;
        end else begin
            value <= valueNext;
            pending <= pendingNext;
            if (cnt.Request) begin
                down <= cnt.Dec;
            end
        end
    end

    assign cnt.Ready = ~|pending;      // Idle once no stage is moving
    assign cnt.Value = value;
    assign cnt.Zero = (value == '0);

endmodule

`default_nettype wire

/* logic/programRom.sv */
`timescale 1ns/1ps
`default_nettype none

module programRom (
    input wire logic Clk,
    input wire logic Rst_n,
    input wire logic LoadStrobe,
    input wire logic [bfPkg::RomAddrWidth-1:0] LoadAddress,
    input var bfPkg::opcodeT LoadData,
    romIf.store rom
);
    import bfPkg::*;

    opcodeT mem [RomDepth];
    logic [IpWidth-1:0] index;         // Binary form of the BCD address
    logic [IpWidth-1:0] readAddress;   // Address of the last read
    logic fetched;                     // First stage of the read delay
    logic readyQ;
    opcodeT word;
    opcodeT dataQ;

    // Weighted sum of the decimal digits, most significant first
    function automatic logic [IpWidth-1:0] bcdToIndex(input logic [IpWidth-1:0] bcd);
        logic [IpWidth-1:0] acc;
        acc = '0;
        for (int i = IpDigits - 1; i >= 0; i--) begin
            acc = IpWidth'(acc * 10) + IpWidth'(bcd[i*DigitWidth +: DigitWidth]);
        end
        return acc;
    endfunction

    assign index = bcdToIndex(rom.Address);

    always_ff @(posedge Clk) begin
        if (LoadStrobe) begin
            mem[LoadAddress] <= LoadData;
        end
    end

    always_ff @(posedge Clk) begin
        if (rom.Request) begin
            // Beyond the array the store reads as Inc
            word <= (index < RomDepth) ? mem[index[RomAddrWidth-1:0]] : Inc;
        end
        if (fetched) begin
            dataQ <= word;
        end
    end

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            readAddress <= '0;
            fetched <= 1'b0;
            readyQ <= 1'b0;
        end else begin
            fetched <= rom.Request;
            if (rom.Request) begin
                readAddress <= rom.Address;
            end
            if (rom.Address != readAddress) begin
                readyQ <= 1'b0;        // Pointer moved away from the word held
            end else if (fetched) begin
                readyQ <= 1'b1;
            end
        end
    end

    assign rom.Ready = readyQ;
    assign rom.Data = dataQ;

endmodule

`default_nettype wire

/* logic/ipLine.sv */
`timescale 1ns/1ps
`default_nettype none

module ipLine (
    input wire logic Clk,
    input wire logic Rst_n,
    input wire logic HaltRq,
    input wire logic DataIsZeroed,
    input wire logic Request,
    output logic Ready,
    output bfPkg::opcodeT Insn,
    counterIf.master ipCnt,
    counterIf.master loopCnt,
    romIf.master rom
);
    import bfPkg::*;

    typedef enum logic [2:0] {
        Idle,
        IpCount,
        RomRead,
        LoopCount,
        Deliver,
        Halt
    } stateT;

    stateT state;
    logic ipReq;
    logic ipDec;
    logic loopReq;
    logic loopDec;
    logic romReq;
    logic backward;    // Scan direction of the skip in progress
    logic skipBack;
    logic skipStart;
    logic romOpen;
    logic romClose;

    // Skip decision on the instruction last delivered
    assign skipBack = (Insn == LoopClose) && !DataIsZeroed;
    assign skipStart = ((Insn == LoopOpen) && DataIsZeroed) || skipBack;

    // Brackets seen on the store output during a scan
    assign romOpen = (rom.Data == LoopOpen);
    assign romClose = (rom.Data == LoopClose);

    assign Ready = (state == Idle) && !Request;

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            state <= Idle;
            Insn <= Inc;
            ipReq <= 1'b0;
            ipDec <= 1'b0;
            loopReq <= 1'b0;
            loopDec <= 1'b0;
            romReq <= 1'b0;
            backward <= 1'b0;
        end else begin
            case (state)
                Idle: begin
                    if (HaltRq) begin
                        state <= Halt;
                    end else if (Request) begin
                        if (!rom.Ready) begin
                            romReq <= 1'b1;        // Nothing read yet, take word 0
                            state <= RomRead;
                        end else if (skipStart) begin
                            backward <= skipBack;
                            loopDec <= 1'b0;       // Starting bracket opens depth 1
                            loopReq <= 1'b1;
                            state <= LoopCount;
                        end else begin
                            backward <= 1'b0;
                            ipDec <= 1'b0;
                            ipReq <= 1'b1;
                            state <= IpCount;
                        end
                    end
                end
                IpCount: begin
                    ipReq <= 1'b0;
                    if (!ipReq && ipCnt.Ready) begin
                        romReq <= 1'b1;
                        state <= RomRead;
                    end
                end
                RomRead: begin
                    romReq <= 1'b0;
                    if (!romReq && rom.Ready) begin
                        if (loopCnt.Zero) begin
                            state <= Deliver;
                        end else if (romOpen || romClose) begin
                            // Against the scan deepens, with the scan closes
                            loopDec <= backward ? romOpen : romClose;
                            loopReq <= 1'b1;
                            state <= LoopCount;
                        end else begin
                            ipDec <= backward;
                            ipReq <= 1'b1;
                            state <= IpCount;
                        end
                    end
                end
                LoopCount: begin
                    loopReq <= 1'b0;
                    if (!loopReq && loopCnt.Ready) begin
                        // Match found, step past it in forward direction
                        ipDec <= backward && !loopCnt.Zero;
                        ipReq <= 1'b1;
                        state <= IpCount;
                    end
                end
                Deliver: begin
                    Insn <= rom.Data;
                    if (!Request) begin
                        state <= Idle;
                    end
                end
                Halt: begin
                    if (!HaltRq) begin
                        state <= Idle;
                    end
                end
                default: begin
                    state <= Idle;
                end
            endcase
        end
    end

    assign ipCnt.Request = ipReq;
    assign ipCnt.Dec = ipDec;
    assign loopCnt.Request = loopReq;
    assign loopCnt.Dec = loopDec;
    assign rom.Request = romReq;
    assign rom.Address = ipCnt.Value;   // Store is addressed straight from the tubes

endmodule

`default_nettype wire

/* logic/bfFetchUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module bfFetchUnit (
    input wire logic Clk,
    input wire logic Rst_n,
    input wire logic HaltRq,
    input wire logic DataIsZeroed,
    input wire logic Request,
    input wire logic LoadStrobe,
    input wire logic [bfPkg::RomAddrWidth-1:0] LoadAddress,
    input wire logic [bfPkg::InsnWidth-1:0] LoadData,
    output logic Ready,
    output logic [bfPkg::IpWidth-1:0] IpAddress,
    output logic [bfPkg::LoopWidth-1:0] LoopCount,
    output logic [bfPkg::InsnWidth-1:0] Insn
);
    import bfPkg::*;

    counterIf #(.DigitNum(IpDigits)) ipIf ();
    counterIf #(.DigitNum(LoopDigits)) loopIf ();
    romIf romBus ();

    opcodeT insnWord;

    dekatronCounter #(.DigitNum(IpDigits)) ipCounter (
        .Clk(Clk),
        .Rst_n(Rst_n),
        .cnt(ipIf.counter)
    );

    // Bracket nesting depth during a skip
    dekatronCounter #(.DigitNum(LoopDigits)) loopCounter (
        .Clk(Clk),
        .Rst_n(Rst_n),
        .cnt(loopIf.counter)
    );

    programRom programRom (
        .Clk(Clk),
        .Rst_n(Rst_n),
        .LoadStrobe(LoadStrobe),
        .LoadAddress(LoadAddress),
        .LoadData(opcodeT'(LoadData)),
        .rom(romBus.store)
    );

    ipLine ipLine (
        .Clk(Clk),
        .Rst_n(Rst_n),
        .HaltRq(HaltRq),
        .DataIsZeroed(DataIsZeroed),
        .Request(Request),
        .Ready(Ready),
        .Insn(insnWord),
        .ipCnt(ipIf.master),
        .loopCnt(loopIf.master),
        .rom(romBus.master)
    );

    assign IpAddress = ipIf.Value;
    assign LoopCount = loopIf.Value;
    assign Insn = insnWord;

endmodule

`default_nettype wire

/* testbench/bfFetchChecker.sv */
`timescale 1ns/1ps
`default_nettype none

module bfFetchChecker (
    input wire logic Clk,
    input wire logic Rst_n,
    input wire logic HaltRq,
    input wire logic DataIsZeroed,
    input wire logic Request,
    input wire logic LoadStrobe,
    input wire logic [bfPkg::RomAddrWidth-1:0] LoadAddress,
    input wire logic [bfPkg::InsnWidth-1:0] LoadData,
    input wire logic Ready,
    input wire logic [bfPkg::IpWidth-1:0] IpAddress,
    input wire logic [bfPkg::LoopWidth-1:0] LoopCount,
    input wire logic [bfPkg::InsnWidth-1:0] Insn
);
    import bfPkg::*;

    logic [InsnWidth-1:0] prog [RomDepth];   // Shadow of the loaded program
    int expPtr;
    int expNext;
    logic first;
    logic pending;      // Fetch accepted and not yet complete
    logic requestQ;
    logic readyQ;
    logic zeroLatched;  // Data flag seen when the fetch began
    logic done;

    // Matching close bracket, scanning forward
    function automatic int matchForward(input int p);
        int depth;
        int i;
        depth = 1;
        i = p;
        while (depth > 0 && i < RomDepth - 1) begin
            i++;
            if (prog[i] == LoopOpen) depth++;
            else if (prog[i] == LoopClose) depth--;
        end
        return i;
    endfunction

    function automatic int matchBackward(input int p);
        int depth;
        int i;
        depth = 1;
        i = p;
        while (depth > 0 && i > 0) begin
            i--;
            if (prog[i] == LoopClose) depth++;
            else if (prog[i] == LoopOpen) depth--;
        end
        return i;
    endfunction

    function automatic logic [IpWidth-1:0] toBcd(input int v);
        return {4'(v / 100 % 10), 4'(v / 10 % 10), 4'(v % 10)};
    endfunction

    always_comb begin
        if (first) expNext = 0;
        else if (prog[expPtr] == LoopOpen && zeroLatched) expNext = matchForward(expPtr) + 1;
        else if (prog[expPtr] == LoopClose && !zeroLatched) expNext = matchBackward(expPtr) + 1;
        else expNext = expPtr + 1;
    end

    assign done = pending && Ready && !readyQ;   // Ready rising ends a fetch

    always_ff @(posedge Clk) begin
        if (LoadStrobe) prog[LoadAddress] <= LoadData;
    end

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            expPtr <= 0;
            first <= 1'b1;
            pending <= 1'b0;
            requestQ <= 1'b0;
            readyQ <= 1'b0;
            zeroLatched <= 1'b0;
        end else begin
            requestQ <= Request;
            readyQ <= Ready;
            if (Request && !requestQ) begin
                pending <= 1'b1;
                zeroLatched <= DataIsZeroed;
            end else if (done) begin
                pending <= 1'b0;
                expPtr <= expNext;
                first <= 1'b0;
            end
        end
    end

    resetState: assert property (@(posedge Clk)
        $rose(Rst_n) |-> Ready && IpAddress == '0 && LoopCount == '0)
        else begin
            $error("mismatch Ready/IpAddress/LoopCount after reset: %h %h %h",
                $sampled(Ready), $sampled(IpAddress), $sampled(LoopCount));
            bfFetchTb.assertErrors++;
        end

    insnMatch: assert property (@(posedge Clk) disable iff (!Rst_n) done |-> Insn == prog[expNext])
        else begin
            $error("mismatch Insn: got %h expected %h", $sampled(Insn), prog[$sampled(expNext)]);
            bfFetchTb.assertErrors++;
        end

    addressMatch: assert property (@(posedge Clk) disable iff (!Rst_n)
        done |-> IpAddress == toBcd(expNext))
        else begin
            $error("mismatch IpAddress: got %h expected %h",
                $sampled(IpAddress), toBcd($sampled(expNext)));
            bfFetchTb.assertErrors++;
        end

    loopIdle: assert property (@(posedge Clk) disable iff (!Rst_n) done |-> LoopCount == '0)
        else begin
            $error("mismatch LoopCount: got %h expected %h", $sampled(LoopCount), 8'h00);
            bfFetchTb.assertErrors++;
        end

    haltHolds: assert property (@(posedge Clk) disable iff (!Rst_n)
        HaltRq && $past(HaltRq) |-> !Ready && $stable(IpAddress) && $stable(Insn))
        else begin
            $error("mismatch Ready/IpAddress/Insn during halt: %h %h %h",
                $sampled(Ready), $sampled(IpAddress), $sampled(Insn));
            bfFetchTb.assertErrors++;
        end

endmodule

`default_nettype wire

/* testbench/bfFetchTb.sv */
`timescale 1ns/1ps
`default_nettype none

module bfFetchTb;
    import bfPkg::*;

    logic Clk;
    logic Rst_n;
    logic HaltRq;
    logic DataIsZeroed;
    logic Request;
    logic LoadStrobe;
    logic [RomAddrWidth-1:0] LoadAddress;
    logic [InsnWidth-1:0] LoadData;
    wire logic Ready;
    wire logic [IpWidth-1:0] IpAddress;
    wire logic [LoopWidth-1:0] LoopCount;
    wire logic [InsnWidth-1:0] Insn;

    int assertErrors = 0;
    int timeouts = 0;
    logic [31:0] lfsr = 32'ha9a41ca7;
    logic [InsnWidth-1:0] progWords [130];

    bfFetchUnit bfFetchUnit_inst (.*);

    bind bfFetchUnit bfFetchChecker fetchChecker (.*);

    always #5 Clk = ~Clk;

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] randomBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic loadProgram();
        for (int i = 0; i < 130; i++) begin
            progWords[i] = InsnWidth'(randomBits(3) % 6);   // No random brackets
        end
        progWords[20] = LoopOpen;   // Two deep nest
        progWords[22] = LoopOpen;
        progWords[24] = LoopClose;
        progWords[26] = LoopClose;
        progWords[40] = LoopOpen;
        progWords[42] = LoopClose;
        for (int b = 60; b <= 80; b += 20) begin
            progWords[b] = LoopOpen;
            progWords[b + 1] = LoopOpen;
            progWords[b + 3] = LoopClose;
            progWords[b + 4] = LoopClose;
        end
        for (int i = 0; i < 130; i++) begin
            @(posedge Clk);
            LoadStrobe <= 1'b1;
            LoadAddress <= RomAddrWidth'(i);
            LoadData <= progWords[i];
        end
        @(posedge Clk);
        LoadStrobe <= 1'b0;
    endtask

    task automatic fetchOnce(input logic zero, input logic halted);
        int t;
        if (halted) begin
            @(posedge Clk);
            HaltRq <= 1'b1;   // Halt taken in idle, the request arrives behind it
        end
        @(posedge Clk);
        Request <= 1'b1;
        DataIsZeroed <= zero;
        if (halted) begin
            repeat (20) @(posedge Clk);
            HaltRq <= 1'b0;
            repeat (20) @(posedge Clk);
        end else begin
            repeat (40) @(posedge Clk);
        end
        Request <= 1'b0;
        t = 0;
        @(negedge Clk);
        while (!Ready && t < 3000) begin
            @(negedge Clk);
            t++;
        end
        if (!Ready) begin
            $display("timeout waiting for Ready after a fetch at IpAddress %h", IpAddress);
            timeouts++;
        end
    endtask

    initial begin
        int fetches;
        int opens;
        int closes;
        logic zero;
        Clk = 1'b0;
        Rst_n = 1'b0;
        HaltRq = 1'b0;
        DataIsZeroed = 1'b0;
        Request = 1'b0;
        LoadStrobe = 1'b0;
        LoadAddress = '0;
        LoadData = '0;
        fetches = 0;
        opens = 0;
        closes = 0;
        repeat (16) @(posedge Clk);
        Rst_n <= 1'b1;
        loadProgram();
        while (fetches < 300 && IpAddress < 12'h125 && timeouts == 0) begin
            // Alternate skip and entry so every bracket case comes up
            if (Insn == LoopOpen) begin
                zero = ~opens[0];
                opens++;
            end else if (Insn == LoopClose) begin
                zero = closes[0];
                closes++;
            end else begin
                zero = 1'(randomBits(1));
            end
            fetchOnce(zero, fetches == 50);
            fetches++;
        end
        repeat (4) @(posedge Clk);
        $display("assertion failures: %0d, timeouts: %0d", assertErrors, timeouts);
        if (assertErrors == 0 && timeouts == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
logic/bfPkg.sv
logic/fetchIfs.sv
logic/dekatronCounter.sv
logic/programRom.sv
logic/ipLine.sv
logic/bfFetchUnit.sv
testbench/bfFetchChecker.sv
testbench/bfFetchTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= bfFetchTb
BUILD_DIR ?= obj_dir
FILE_LIST ?= src.f
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
RUN_ARGS ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	grep -q "all tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
